//--- src/muldiv_pkg.sv
// shared constants and message types for the iterative multiply/divide unit
// imported by every RTL module and by the testbench
`default_nettype none

package muldiv_pkg;

  // ------------------------------
  // widths and iteration counts
  // ------------------------------
  localparam int DATA_W      = 32;
  localparam int RESULT_W    = 64;
  localparam int ITER_N      = 32;
  localparam int COUNT_W     = 6;

  // issue-order queue, depth must stay a power of two
  localparam int ORDER_DEPTH = 2;
  localparam int ORDER_PTR_W = 1;
  localparam int ORDER_CNT_W = 2;

  // ------------------------------
  // message types
  // ------------------------------
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } muldiv_fn_t;

  typedef struct packed {
    muldiv_fn_t        fn;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } muldiv_req_t;

  // divide: remainder in hi, quotient in lo; multiply: full product
  typedef struct packed {
    logic [DATA_W-1:0] hi;
    logic [DATA_W-1:0] lo;
  } muldiv_result_t;

  typedef enum logic {
    UNIT_MUL = 1'b0,
    UNIT_DIV = 1'b1
  } muldiv_unit_t;

endpackage

`default_nettype wire

//--- src/val_rdy_pipe_reg.sv
// one-entry val/rdy register stage
// set payload_t to the message type carried across the boundary
`timescale 1ns/10ps
`default_nettype none

module val_rdy_pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     reset,

  input  logic     in_val,
  output logic     in_rdy,
  input  payload_t in_msg,

  output logic     out_val,
  input  logic     out_rdy,
  output payload_t out_msg
);

  logic     full;
  payload_t data;
  logic     in_go;

  // accept when empty or when the held entry drains this cycle
  assign in_rdy = !full || out_rdy;
  assign in_go  = in_val && in_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in_go) begin
      full <= 1'b1;
    end else if (out_rdy) begin
      full <= 1'b0;
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (in_go) begin
      data <= in_msg;
    end
  end

  assign out_val = full;
  assign out_msg = data;

  // stalled output holds val and payload until taken
  out_stable_a: assert property (@(posedge clk) disable iff (reset)
    (out_val && !out_rdy) |=> (out_val && $stable(out_msg)));

endmodule

`default_nettype wire

//--- src/int_div_dpath.sv
// restoring divider datapath, steered by int_div_iterative
// holds remainder/quotient and divisor registers plus the sign fix-up
`timescale 1ns/10ps
`default_nettype none

module int_div_dpath (
  input  logic                       clk,
  input  logic                       reset,
  input  muldiv_pkg::muldiv_req_t    req_msg,
  input  logic                       a_en,
  input  logic                       b_en,
  input  logic                       a_mux_sel,
  input  logic                       sub_mux_sel,
  output muldiv_pkg::muldiv_result_t result
);

  import muldiv_pkg::*;

  logic [2*DATA_W:0] rq_reg;
  logic [2*DATA_W:0] d_reg;
  logic              sign_a;
  logic              sign_b;

  logic              is_signed;
  logic [DATA_W-1:0] a_mag;
  logic [DATA_W-1:0] b_mag;
  logic [2*DATA_W:0] initial_a;
  logic [2*DATA_W:0] initial_b;
  logic [2*DATA_W:0] shifted;
  logic [2*DATA_W:0] diff;
  logic [2*DATA_W:0] step_out;
  logic [2*DATA_W:0] fixed;
  logic [2*DATA_W:0] sub_mux_out;
  logic [2*DATA_W:0] a_mux_out;
  logic [DATA_W-1:0] quo_fix;
  logic [DATA_W-1:0] rem_fix;

  // ------------------------------
  // operand load
  // ------------------------------
  // signs only count for the signed divide
  assign is_signed = req_msg.fn == FN_DIV;
  assign a_mag = (is_signed && req_msg.a[DATA_W-1]) ? -req_msg.a : req_msg.a;
  assign b_mag = (is_signed && req_msg.b[DATA_W-1]) ? -req_msg.b : req_msg.b;

  // dividend sits low, divisor lines up with the upper word
  assign initial_a = {{(DATA_W+1){1'b0}}, a_mag};
  assign initial_b = {1'b0, b_mag, {DATA_W{1'b0}}};

  // ------------------------------
  // shift-subtract step
  // ------------------------------
  assign shifted = rq_reg << 1;
  assign diff    = shifted - d_reg;
  // non-negative difference keeps it and sets the quotient bit
  assign step_out = diff[2*DATA_W] ? shifted : {diff[2*DATA_W:1], 1'b1};

  // final pass applies the signs in place
  assign quo_fix = (sign_a ^ sign_b) ? -rq_reg[DATA_W-1:0] : rq_reg[DATA_W-1:0];
  assign rem_fix = sign_a ? -rq_reg[2*DATA_W-1:DATA_W] : rq_reg[2*DATA_W-1:DATA_W];
  assign fixed   = {1'b0, rem_fix, quo_fix};

  assign sub_mux_out = sub_mux_sel ? fixed : step_out;
  assign a_mux_out   = a_mux_sel ? sub_mux_out : initial_a;

  always_ff @(posedge clk) begin
    if (a_en) begin
      rq_reg <= a_mux_out;
    end
    if (b_en) begin
      d_reg <= initial_b;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a <= 1'b0;
      sign_b <= 1'b0;
    end else if (b_en) begin
      sign_a <= is_signed && req_msg.a[DATA_W-1];
      sign_b <= is_signed && req_msg.b[DATA_W-1];
    end
  end

  // remainder in hi, quotient in lo
  assign result = rq_reg[2*DATA_W-1:0];

endmodule

`default_nettype wire

//--- src/int_div_iterative.sv
// iterative divider: control FSM over int_div_dpath
// one operation at a time, result held until the response transfer
`timescale 1ns/10ps
`default_nettype none

module int_div_iterative (
  input  logic                       clk,
  input  logic                       reset,

  input  logic                       req_val,
  output logic                       req_rdy,
  input  muldiv_pkg::muldiv_req_t    req_msg,

  output logic                       resp_val,
  input  logic                       resp_rdy,
  output muldiv_pkg::muldiv_result_t resp_msg
);

  import muldiv_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_t;

  state_t             state;
  logic [COUNT_W-1:0] count;
  logic               req_go;
  logic               resp_go;
  logic               last_step;

  logic               a_en;
  logic               b_en;
  logic               a_mux_sel;
  logic               sub_mux_sel;

  int_div_dpath dpath (
    .clk         (clk),
    .reset       (reset),
    .req_msg     (req_msg),
    .a_en        (a_en),
    .b_en        (b_en),
    .a_mux_sel   (a_mux_sel),
    .sub_mux_sel (sub_mux_sel),
    .result      (resp_msg)
  );

  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  // counts 0..ITER_N-1 are steps, ITER_N is the sign fix-up pass
  assign last_step = count == COUNT_W'(ITER_N);

  assign req_rdy  = state == IDLE;
  assign resp_val = state == DONE;

  // ------------------------------
  // state and counter
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          if (last_step) begin
            state <= DONE;
          end
          count <= count + 1'b1;
        end
        default: begin
          if (resp_go) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  // ------------------------------
  // datapath controls
  // ------------------------------
  always_comb begin
    a_en        = 1'b0;
    b_en        = 1'b0;
    a_mux_sel   = 1'b0;
    sub_mux_sel = 1'b0;
    case (state)
      IDLE: begin
        // load magnitudes and signs on the accept edge
        a_en = req_go;
        b_en = req_go;
      end
      CALC: begin
        a_en        = 1'b1;
        a_mux_sel   = 1'b1;
        sub_mux_sel = last_step;
      end
      default: begin
      end
    endcase
  end

  // busy for the full run after an accept, then the result appears
  busy_a: assert property (@(posedge clk) disable iff (reset)
    req_go |=> (!req_rdy [*ITER_N+1]) ##1 resp_val);

endmodule

`default_nettype wire

//--- src/int_mul_iterative.sv
// iterative shift-add multiplier, full signed 64-bit product
// same val/rdy timing as the divider: result 33 cycles after accept
`timescale 1ns/10ps
`default_nettype none

module int_mul_iterative (
  input  logic                       clk,
  input  logic                       reset,

  input  logic                       req_val,
  output logic                       req_rdy,
  input  muldiv_pkg::muldiv_req_t    req_msg,

  output logic                       resp_val,
  input  logic                       resp_rdy,
  output muldiv_pkg::muldiv_result_t resp_msg
);

  import muldiv_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_t;

  state_t              state;
  logic [COUNT_W-1:0]  count;
  logic                req_go;
  logic                resp_go;
  logic                last_step;

  logic [RESULT_W-1:0] acc;
  logic [RESULT_W-1:0] mcand;
  logic [DATA_W-1:0]   mplier;
  logic                neg;
  logic [DATA_W-1:0]   a_mag;
  logic [DATA_W-1:0]   b_mag;

  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_step = count == COUNT_W'(ITER_N);

  assign req_rdy  = state == IDLE;
  assign resp_val = state == DONE;

  // most negative value maps to 2^31, still correct as unsigned
  assign a_mag = req_msg.a[DATA_W-1] ? -req_msg.a : req_msg.a;
  assign b_mag = req_msg.b[DATA_W-1] ? -req_msg.b : req_msg.b;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          if (last_step) begin
            state <= DONE;
          end
          count <= count + 1'b1;
        end
        default: begin
          if (resp_go) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  // ------------------------------
  // shift-add datapath
  // ------------------------------
  always_ff @(posedge clk) begin
    if (req_go) begin
      acc    <= '0;
      mcand  <= {{(RESULT_W-DATA_W){1'b0}}, a_mag};
      mplier <= b_mag;
      neg    <= req_msg.a[DATA_W-1] ^ req_msg.b[DATA_W-1];
    end else if (state == CALC) begin
      if (!last_step) begin
        // add for each set multiplier bit, lsb first
        if (mplier[0]) begin
          acc <= acc + mcand;
        end
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end else if (neg) begin
        acc <= -acc;
      end
    end
  end

  assign resp_msg = acc;

endmodule

`default_nettype wire

//--- src/muldiv_dispatch.sv
// routes requests to the multiplier or divider and returns results in issue order
// a small queue of unit ids remembers which unit answers next
`timescale 1ns/10ps
`default_nettype none

module muldiv_dispatch (
  input  logic                       clk,
  input  logic                       reset,

  input  logic                       in_val,
  output logic                       in_rdy,
  input  muldiv_pkg::muldiv_req_t    in_msg,

  output logic                       mul_req_val,
  input  logic                       mul_req_rdy,
  output logic                       div_req_val,
  input  logic                       div_req_rdy,
  output muldiv_pkg::muldiv_req_t    unit_req_msg,

  input  logic                       mul_resp_val,
  output logic                       mul_resp_rdy,
  input  muldiv_pkg::muldiv_result_t mul_resp_msg,
  input  logic                       div_resp_val,
  output logic                       div_resp_rdy,
  input  muldiv_pkg::muldiv_result_t div_resp_msg,

  output logic                       out_val,
  input  logic                       out_rdy,
  output muldiv_pkg::muldiv_result_t out_msg
);

  import muldiv_pkg::*;

  muldiv_unit_t           order_q [ORDER_DEPTH];
  logic [ORDER_PTR_W-1:0] wr_ptr;
  logic [ORDER_PTR_W-1:0] rd_ptr;
  logic [ORDER_CNT_W-1:0] order_cnt;
  logic                   is_mul;
  logic                   q_full;
  logic                   q_empty;
  logic                   push;
  logic                   pop;
  muldiv_unit_t           head;

  // ------------------------------
  // request side
  // ------------------------------
  assign is_mul  = in_msg.fn == FN_MUL;
  assign q_full  = order_cnt == ORDER_CNT_W'(ORDER_DEPTH);
  assign q_empty = order_cnt == '0;

  assign unit_req_msg = in_msg;
  assign mul_req_val  = in_val && is_mul && !q_full;
  assign div_req_val  = in_val && !is_mul && !q_full;
  assign in_rdy       = !q_full && (is_mul ? mul_req_rdy : div_req_rdy);
  assign push         = in_val && in_rdy;

  // ------------------------------
  // response side
  // ------------------------------
  // only the unit at the head may respond
  assign head         = order_q[rd_ptr];
  assign out_val      = !q_empty && ((head == UNIT_MUL) ? mul_resp_val : div_resp_val);
  assign out_msg      = (head == UNIT_MUL) ? mul_resp_msg : div_resp_msg;
  assign mul_resp_rdy = !q_empty && (head == UNIT_MUL) && out_rdy;
  assign div_resp_rdy = !q_empty && (head == UNIT_DIV) && out_rdy;
  assign pop          = out_val && out_rdy;

  always_ff @(posedge clk) begin
    if (push) begin
      order_q[wr_ptr] <= is_mul ? UNIT_MUL : UNIT_DIV;
    end
  end

  // pointers wrap on their own at a power-of-two depth
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      order_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   order_cnt <= order_cnt + 1'b1;
        2'b01:   order_cnt <= order_cnt - 1'b1;
        default: order_cnt <= order_cnt;
      endcase
    end
  end

  // a full queue means both units hold an operation
  order_max_a: assert property (@(posedge clk) disable iff (reset)
    q_full |-> (!mul_req_rdy && !div_req_rdy));

  // a unit holding a result always has an entry queued for it
  order_min_a: assert property (@(posedge clk) disable iff (reset)
    (mul_resp_val || div_resp_val) |-> !q_empty);

endmodule

`default_nettype wire

//--- src/int_muldiv_iterative.sv
// top level of the iterative multiply/divide unit
// registered request and response ports around dispatch and the two units
`timescale 1ns/10ps
`default_nettype none

module int_muldiv_iterative (
  input  logic                       clk,
  input  logic                       reset,

  input  logic                       req_val,
  output logic                       req_rdy,
  input  muldiv_pkg::muldiv_req_t    req_msg,

  output logic                       resp_val,
  input  logic                       resp_rdy,
  output muldiv_pkg::muldiv_result_t resp_msg
);

  import muldiv_pkg::*;

  logic           disp_in_val;
  logic           disp_in_rdy;
  muldiv_req_t    disp_in_msg;

  logic           mul_req_val;
  logic           mul_req_rdy;
  logic           div_req_val;
  logic           div_req_rdy;
  muldiv_req_t    unit_req_msg;

  logic           mul_resp_val;
  logic           mul_resp_rdy;
  muldiv_result_t mul_resp_msg;
  logic           div_resp_val;
  logic           div_resp_rdy;
  muldiv_result_t div_resp_msg;

  logic           disp_out_val;
  logic           disp_out_rdy;
  muldiv_result_t disp_out_msg;

  val_rdy_pipe_reg #(.payload_t(muldiv_req_t)) req_stage (
    .clk     (clk),
    .reset   (reset),
    .in_val  (req_val),
    .in_rdy  (req_rdy),
    .in_msg  (req_msg),
    .out_val (disp_in_val),
    .out_rdy (disp_in_rdy),
    .out_msg (disp_in_msg)
  );

  muldiv_dispatch dispatch (
    .clk          (clk),
    .reset        (reset),
    .in_val       (disp_in_val),
    .in_rdy       (disp_in_rdy),
    .in_msg       (disp_in_msg),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .unit_req_msg (unit_req_msg),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .mul_resp_msg (mul_resp_msg),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy),
    .div_resp_msg (div_resp_msg),
    .out_val      (disp_out_val),
    .out_rdy      (disp_out_rdy),
    .out_msg      (disp_out_msg)
  );

  int_mul_iterative mul_unit (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .req_msg  (unit_req_msg),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .resp_msg (mul_resp_msg)
  );

  int_div_iterative div_unit (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .req_msg  (unit_req_msg),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .resp_msg (div_resp_msg)
  );

  val_rdy_pipe_reg #(.payload_t(muldiv_result_t)) resp_stage (
    .clk     (clk),
    .reset   (reset),
    .in_val  (disp_out_val),
    .in_rdy  (disp_out_rdy),
    .in_msg  (disp_out_msg),
    .out_val (resp_val),
    .out_rdy (resp_rdy),
    .out_msg (resp_msg)
  );

endmodule

`default_nettype wire

//--- include/tb_muldiv_model.svh
// reference functions for the testbench scoreboard
// included inside the testbench module to give the expected result of each request
`ifndef TB_MULDIV_MODEL_SVH
`define TB_MULDIV_MODEL_SVH

// ------------------------------
// signed and unsigned divide
// ------------------------------
function automatic muldiv_pkg::muldiv_result_t divide_result(
  input muldiv_pkg::muldiv_fn_t fn,
  input logic [31:0]            a,
  input logic [31:0]            b
);
  logic                       sign_a;
  logic                       sign_b;
  logic [31:0]                a_mag;
  logic [31:0]                b_mag;
  logic [31:0]                quo;
  logic [31:0]                rem;
  muldiv_pkg::muldiv_result_t res;
  sign_a = (fn == muldiv_pkg::FN_DIV) && a[31];
  sign_b = (fn == muldiv_pkg::FN_DIV) && b[31];
  a_mag  = sign_a ? -a : a;
  b_mag  = sign_b ? -b : b;
  // divide by zero gives all-ones quotient and the dividend as remainder
  if (b_mag == 32'd0) begin
    quo = 32'hffff_ffff;
    rem = a_mag;
  end else begin
    quo = a_mag / b_mag;
    rem = a_mag % b_mag;
  end
  res.lo = (sign_a ^ sign_b) ? -quo : quo;
  res.hi = sign_a ? -rem : rem;
  return res;
endfunction

// full signed product
function automatic muldiv_pkg::muldiv_result_t multiply_result(
  input logic [31:0] a,
  input logic [31:0] b
);
  logic signed [63:0] prod;
  prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
  return prod;
endfunction

function automatic muldiv_pkg::muldiv_result_t expected_result(
  input muldiv_pkg::muldiv_req_t req
);
  if (req.fn == muldiv_pkg::FN_MUL) begin
    return multiply_result(req.a, req.b);
  end else begin
    return divide_result(req.fn, req.a, req.b);
  end
endfunction

`endif

//--- sim/tb_int_muldiv.sv
// testbench for the iterative multiply/divide unit
// directed and random requests with responses checked against the reference model
`timescale 1ns/10ps
`default_nettype none

module tb_int_muldiv;

  import muldiv_pkg::*;

  `include "tb_muldiv_model.svh"

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 10;
  localparam int N_RAND          = 20;
  localparam int N_MIXED         = 40;
  // requests over tests 1 to 6
  localparam int TOTAL_REQS      = 1 + (5 + N_RAND) + (5 + N_RAND) + 5 + (4 + N_RAND) + N_MIXED;
  // about 40 cycles per request and a fixed margin
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_REQS * 40 + 200;

  logic           clk;
  logic           reset;
  logic           req_val;
  logic           req_rdy;
  muldiv_req_t    req_msg;
  logic           resp_val;
  logic           resp_rdy;
  muldiv_result_t resp_msg;

  int             seed = 32'hf0e4ac57;
  int             rdy_seed;
  logic [31:0]    rdy_draw;
  logic           lone_mode;
  logic           bp_mode;

  // scoreboard
  muldiv_result_t exp_q [$];
  muldiv_result_t exp_head;
  int             exp_cnt;
  int             req_count;
  int             resp_count;
  int             errors;
  int             tests_run;
  int             base_reqs;
  int             base_errors;

  int_muldiv_iterative dut (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // random back-pressure drawn on every falling edge
  initial begin
    rdy_seed = seed + 1;
    resp_rdy = 1'b1;
    forever begin
      @(negedge clk);
      rdy_draw = $random(rdy_seed);
      resp_rdy = bp_mode ? rdy_draw[0] : 1'b1;
    end
  end

  // ------------------------------
  // expected results in issue order
  // ------------------------------
  always @(posedge clk) begin
    if (reset) begin
      exp_q.delete();
      exp_head <= '0;
      exp_cnt  <= 0;
    end else begin
      if (resp_val && resp_rdy) begin
        resp_count++;
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(expected_result(req_msg));
        req_count++;
      end
      exp_cnt  <= exp_q.size();
      exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  resp_value_a: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> (resp_msg == exp_head))
    else begin
      $display("Error at %0t: resp_msg expected %h got %h",
               $time, $sampled(exp_head), $sampled(resp_msg));
      errors++;
    end

  // a response with nothing outstanding means a duplicate
  no_extra_resp_a: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> (exp_cnt != 0))
    else begin
      $display("response offered at %0t with no request outstanding", $time);
      errors++;
    end

  after_reset_a: assert property (@(posedge clk)
    $fell(reset) |-> (!resp_val && req_rdy))
    else begin
      $display("at %0t the DUT was not idle and ready right after reset", $time);
      errors++;
    end

  in_reset_a: assert property (@(posedge clk)
    reset |=> !resp_val)
    else begin
      $display("resp_val was high during reset at %0t", $time);
      errors++;
    end

  // a lone request sees resp_val low for 35 cycles and then high
  lone_latency_a: assert property (@(posedge clk) disable iff (reset)
    (lone_mode && req_val && req_rdy && exp_cnt == 0) |=> (!resp_val [*35]) ##1 resp_val)
    else begin
      $display("resp_val did not rise exactly 35 cycles after the lone request, at %0t",
               $time);
      errors++;
    end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  function automatic muldiv_req_t make_req(input muldiv_fn_t fn, input logic [31:0] a,
                                           input logic [31:0] b);
    muldiv_req_t r;
    r.fn = fn;
    r.a  = a;
    r.b  = b;
    return r;
  endfunction

  // arithmetic shift by a random amount spreads the magnitudes and keeps the sign
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    int          sh;
    w  = $random(seed);
    sh = $unsigned($random(seed)) % 32;
    return $signed(w) >>> sh;
  endfunction

  function automatic muldiv_fn_t rand_fn();
    int pick;
    pick = $unsigned($random(seed)) % 3;
    case (pick)
      0: return FN_MUL;
      1: return FN_DIV;
      default: return FN_DIVU;
    endcase
  endfunction

  // starts on a falling edge and returns on the falling edge after the transfer
  task automatic send_req(input muldiv_req_t r);
    req_val = 1'b1;
    req_msg = r;
    // req_rdy depends on registers only and is settled here
    while (!req_rdy) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic drain_responses();
    req_val = 1'b0;
    while (exp_cnt != 0) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
  endtask

  task automatic report_test(input string name);
    $display("%s: requests %0d, errors %0d", name, req_count - base_reqs, errors - base_errors);
    base_reqs   = req_count;
    base_errors = errors;
    tests_run++;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    muldiv_fn_t  fn;
    logic [31:0] a;
    logic [31:0] b;
    reset       = 1'b1;
    req_val     = 1'b0;
    req_msg     = '0;
    lone_mode   = 1'b0;
    bp_mode     = 1'b0;
    req_count   = 0;
    resp_count  = 0;
    errors      = 0;
    tests_run   = 0;
    base_reqs   = 0;
    base_errors = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // test 1 checks idle after reset and one request on an empty pipe
    lone_mode = 1'b1;
    send_req(make_req(FN_DIVU, 32'd100, 32'd7));
    drain_responses();
    lone_mode = 1'b0;
    report_test("test 1 reset and latency");

    // test 2 unsigned divide
    send_req(make_req(FN_DIVU, 32'd100, 32'd7));
    send_req(make_req(FN_DIVU, 32'hffff_ffff, 32'd1));
    send_req(make_req(FN_DIVU, 32'hffff_ffff, 32'hffff_ffff));
    send_req(make_req(FN_DIVU, 32'd5, 32'd10));
    send_req(make_req(FN_DIVU, 32'h8000_0000, 32'd3));
    for (int i = 0; i < N_RAND; i++) begin
      send_req(make_req(FN_DIVU, rand_word(), rand_word()));
    end
    drain_responses();
    report_test("test 2 unsigned divide");

    // test 3 signed divide with all four sign combinations and overflow
    send_req(make_req(FN_DIV, 32'd7, 32'd2));
    send_req(make_req(FN_DIV, -32'd7, 32'd2));
    send_req(make_req(FN_DIV, 32'd7, -32'd2));
    send_req(make_req(FN_DIV, -32'd7, -32'd2));
    send_req(make_req(FN_DIV, 32'h8000_0000, 32'hffff_ffff));
    for (int i = 0; i < N_RAND; i++) begin
      send_req(make_req(FN_DIV, rand_word(), rand_word()));
    end
    drain_responses();
    report_test("test 3 signed divide");

    // test 4 divide by zero, signed and unsigned
    send_req(make_req(FN_DIV, 32'd123, 32'd0));
    send_req(make_req(FN_DIV, -32'd123, 32'd0));
    send_req(make_req(FN_DIV, 32'd0, 32'd0));
    send_req(make_req(FN_DIVU, 32'hdead_beef, 32'd0));
    send_req(make_req(FN_DIVU, 32'hffff_ffff, 32'd0));
    drain_responses();
    report_test("test 4 divide by zero");

    // test 5 signed multiply with the most negative value included
    send_req(make_req(FN_MUL, 32'h8000_0000, 32'h8000_0000));
    send_req(make_req(FN_MUL, 32'h8000_0000, 32'hffff_ffff));
    send_req(make_req(FN_MUL, 32'h7fff_ffff, 32'h7fff_ffff));
    send_req(make_req(FN_MUL, 32'hffff_ffff, 32'hffff_ffff));
    for (int i = 0; i < N_RAND; i++) begin
      send_req(make_req(FN_MUL, rand_word(), rand_word()));
    end
    drain_responses();
    report_test("test 5 multiply");

    // test 6 mixed back-to-back stream under back-pressure
    bp_mode = 1'b1;
    for (int i = 0; i < N_MIXED; i++) begin
      fn = rand_fn();
      a  = rand_word();
      // an occasional zero divisor
      b  = (($random(seed) & 7) == 0) ? 32'd0 : rand_word();
      send_req(make_req(fn, a, b));
    end
    drain_responses();
    bp_mode = 1'b0;
    report_test("test 6 mixed with back-pressure");

    all_answered: assert (resp_count == req_count)
      else begin
        $display("response count mismatch: %0d requests but %0d responses",
                 req_count, resp_count);
        errors++;
      end

    $display("tests %0d, requests %0d, responses %0d, errors %0d",
             tests_run, req_count, resp_count, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- muldiv.f
+incdir+include
src/muldiv_pkg.sv
src/val_rdy_pipe_reg.sv
src/int_div_dpath.sv
src/int_div_iterative.sv
src/int_mul_iterative.sv
src/muldiv_dispatch.sv
src/int_muldiv_iterative.sv
sim/tb_int_muldiv.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the muldiv testbench with Verilator, run it and check the log
set -e
set -o pipefail
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_int_muldiv \
  -Mdir "$BUILD_DIR" \
  -f muldiv.f

"./$BUILD_DIR/Vtb_int_muldiv" | tee "$LOG"

if grep -q "Finished with no errors" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
